// ==== hw/mini65_defs.svh ====
`ifndef MINI65_DEFS_SVH
`define MINI65_DEFS_SVH

// Bus widths
`define MINI65_DATA_W     8
`define MINI65_ADDR_W     16
`define MINI65_ALU_OP_W   4

// First opcode fetch after reset
`define MINI65_RESET_PC   16'h0200

// Supported opcodes, standard 6502 encodings
`define MINI65_OP_LDA_IMM 8'hA9
`define MINI65_OP_LDX_IMM 8'hA2
`define MINI65_OP_LDA_ABS 8'hAD
`define MINI65_OP_STA_ABS 8'h8D
`define MINI65_OP_STX_ABS 8'h8E
`define MINI65_OP_ADC_IMM 8'h69
`define MINI65_OP_AND_IMM 8'h29
`define MINI65_OP_ORA_IMM 8'h09
`define MINI65_OP_EOR_IMM 8'h49
`define MINI65_OP_INX     8'hE8
`define MINI65_OP_DEX     8'hCA
`define MINI65_OP_TAX     8'hAA
`define MINI65_OP_CLC     8'h18
`define MINI65_OP_SEC     8'h38
`define MINI65_OP_JMP_ABS 8'h4C
// Real NOP, handled like any unknown opcode
`define MINI65_OP_NOP     8'hEA

// ALU operation codes
`define MINI65_ALU_LOAD   4'd0
`define MINI65_ALU_ADC    4'd1
`define MINI65_ALU_AND    4'd2
`define MINI65_ALU_ORA    4'd3
`define MINI65_ALU_EOR    4'd4
`define MINI65_ALU_INC    4'd5
`define MINI65_ALU_DEC    4'd6
`define MINI65_ALU_XFER   4'd7
`define MINI65_ALU_CLC    4'd8
`define MINI65_ALU_SEC    4'd9

// Address source select
`define MINI65_ADDR_SEL_PC   1'b0
`define MINI65_ADDR_SEL_OPND 1'b1

`endif

// ==== hw/mini65_pkg.sv ====
`include "mini65_defs.svh"

package mini65_pkg;

    // One data byte on the bus
    typedef logic [`MINI65_DATA_W-1:0] data_t;

    // Full bus address
    typedef logic [`MINI65_ADDR_W-1:0] addr_t;

    // Execute stage operation code
    typedef logic [`MINI65_ALU_OP_W-1:0] alu_op_t;

    // Address source, PC or operand latch
    typedef logic [0:0] addr_sel_t;

    // Bus cycle of the current instruction
    typedef enum logic [2:0] {
        FETCH,
        OPERAND_LO,
        OPERAND_HI,
        MEM_ACCESS,
        IMPLIED
    } cpu_state_t;

endpackage

// ==== hw/instruction_decoder.sv ====
`timescale 1ns/100ps
`include "mini65_defs.svh"

module instruction_decoder (
    input  logic                  fclk,
    input  logic                  rst_n,
    input  logic                  rdy,
    input  mini65_pkg::data_t     data_in,
    output mini65_pkg::alu_op_t   alu_op,
    output logic                  a_we,
    output logic                  x_we,
    output logic                  c_we,
    output logic                  store_x,
    output logic                  pc_inc,
    output logic                  pc_jump,
    output logic                  lo_we,
    output logic                  hi_we,
    output mini65_pkg::addr_sel_t addr_sel,
    output logic                  rwb,
    output logic                  sync
);

    mini65_pkg::cpu_state_t state;
    mini65_pkg::cpu_state_t state_nxt;
    mini65_pkg::data_t      op_reg;
    mini65_pkg::data_t      cur_op;

    // Opcode class and destination
    logic is_imm;
    logic is_abs;
    logic is_jmp;
    logic is_store;
    logic dst_a;
    logic dst_x;
    logic dst_c;
    logic src_x;
    logic last_cycle;

    // Opcode is still on the bus during FETCH
    assign cur_op = (state == mini65_pkg::FETCH) ? data_in : op_reg;

    ////////////////////////////////////////////////////////////
    // Opcode classification
    ////////////////////////////////////////////////////////////
    always_comb begin
        is_imm   = 1'b0;
        is_abs   = 1'b0;
        is_jmp   = 1'b0;
        is_store = 1'b0;
        dst_a    = 1'b0;
        dst_x    = 1'b0;
        dst_c    = 1'b0;
        src_x    = 1'b0;
        alu_op   = `MINI65_ALU_LOAD;
        case (cur_op)
            `MINI65_OP_LDA_IMM: begin
                is_imm = 1'b1;
                dst_a  = 1'b1;
            end
            `MINI65_OP_LDX_IMM: begin
                is_imm = 1'b1;
                dst_x  = 1'b1;
            end
            `MINI65_OP_ADC_IMM: begin
                is_imm = 1'b1;
                dst_a  = 1'b1;
                dst_c  = 1'b1;
                alu_op = `MINI65_ALU_ADC;
            end
            `MINI65_OP_AND_IMM, `MINI65_OP_ORA_IMM, `MINI65_OP_EOR_IMM: begin
                is_imm = 1'b1;
                dst_a  = 1'b1;
                // Bits 6:5 pick the logic op
                alu_op = (cur_op == `MINI65_OP_AND_IMM) ? `MINI65_ALU_AND :
                         (cur_op == `MINI65_OP_ORA_IMM) ? `MINI65_ALU_ORA :
                                                          `MINI65_ALU_EOR;
            end
            `MINI65_OP_LDA_ABS: begin
                is_abs = 1'b1;
                dst_a  = 1'b1;
            end
            `MINI65_OP_STA_ABS, `MINI65_OP_STX_ABS: begin
                is_abs   = 1'b1;
                is_store = 1'b1;
                src_x    = (cur_op == `MINI65_OP_STX_ABS);
            end
            `MINI65_OP_JMP_ABS: is_jmp = 1'b1;
            `MINI65_OP_INX, `MINI65_OP_DEX: begin
                dst_x  = 1'b1;
                alu_op = (cur_op == `MINI65_OP_INX) ? `MINI65_ALU_INC : `MINI65_ALU_DEC;
            end
            `MINI65_OP_TAX: begin
                dst_x  = 1'b1;
                alu_op = `MINI65_ALU_XFER;
            end
            `MINI65_OP_CLC, `MINI65_OP_SEC: begin
                dst_c  = 1'b1;
                alu_op = (cur_op == `MINI65_OP_CLC) ? `MINI65_ALU_CLC : `MINI65_ALU_SEC;
            end
            // Anything else falls through as a one-byte no-op
            default: ;
        endcase
    end

    ////////////////////////////////////////////////////////////
    // Bus cycle sequencing
    ////////////////////////////////////////////////////////////
    always_comb begin
        state_nxt = mini65_pkg::FETCH;
        case (state)
            mini65_pkg::FETCH:
                state_nxt = (is_imm || is_abs || is_jmp) ? mini65_pkg::OPERAND_LO
                                                         : mini65_pkg::IMPLIED;
            mini65_pkg::OPERAND_LO:
                state_nxt = is_imm ? mini65_pkg::FETCH : mini65_pkg::OPERAND_HI;
            mini65_pkg::OPERAND_HI:
                state_nxt = is_jmp ? mini65_pkg::FETCH : mini65_pkg::MEM_ACCESS;
            default:
                state_nxt = mini65_pkg::FETCH;
        endcase
    end

    always_ff @(posedge fclk) begin
        if (!rst_n) begin
            state <= mini65_pkg::FETCH;
        end else if (rdy) begin
            state <= state_nxt;
        end
    end

    // Opcode byte captured at end of fetch
    always_ff @(posedge fclk) begin
        if (rdy && state == mini65_pkg::FETCH) begin
            op_reg <= data_in;
        end
    end

    ////////////////////////////////////////////////////////////
    // Strobes per cycle
    ////////////////////////////////////////////////////////////
    // Cycle in which results land
    assign last_cycle = (state == mini65_pkg::OPERAND_LO && is_imm) ||
                        (state == mini65_pkg::MEM_ACCESS) ||
                        (state == mini65_pkg::IMPLIED);

    assign a_we    = last_cycle && dst_a;
    assign x_we    = last_cycle && dst_x;
    assign c_we    = last_cycle && dst_c;
    assign store_x = (state == mini65_pkg::MEM_ACCESS) && src_x;

    // PC steps past opcode and operand bytes only
    assign pc_inc  = (state == mini65_pkg::FETCH) ||
                     (state == mini65_pkg::OPERAND_LO) ||
                     (state == mini65_pkg::OPERAND_HI && is_abs);
    assign pc_jump = (state == mini65_pkg::OPERAND_HI) && is_jmp;
    assign lo_we   = (state == mini65_pkg::OPERAND_LO) && (is_abs || is_jmp);
    assign hi_we   = (state == mini65_pkg::OPERAND_HI) && is_abs;

    assign addr_sel = (state == mini65_pkg::MEM_ACCESS) ? `MINI65_ADDR_SEL_OPND
                                                        : `MINI65_ADDR_SEL_PC;
    // Write only in the data cycle of a store
    assign rwb  = !((state == mini65_pkg::MEM_ACCESS) && is_store);
    assign sync = (state == mini65_pkg::FETCH);

endmodule

// ==== hw/alu.sv ====
`timescale 1ns/100ps
`include "mini65_defs.svh"

module alu (
    input  mini65_pkg::alu_op_t alu_op,
    input  mini65_pkg::data_t   acc,
    input  mini65_pkg::data_t   x_reg,
    input  mini65_pkg::data_t   data_in,
    input  logic                carry,
    output mini65_pkg::data_t   result,
    output logic                carry_out
);

    // Binary add with carry, top bit is carry out
    logic [`MINI65_DATA_W:0] sum;

    assign sum = {1'b0, acc} + {1'b0, data_in} + {{`MINI65_DATA_W{1'b0}}, carry};

    always_comb begin
        // Carry held unless the op says otherwise
        result    = data_in;
        carry_out = carry;
        case (alu_op)
            `MINI65_ALU_LOAD: result = data_in;
            `MINI65_ALU_ADC: begin
                result    = sum[`MINI65_DATA_W-1:0];
                carry_out = sum[`MINI65_DATA_W];
            end
            `MINI65_ALU_AND: result = acc & data_in;
            `MINI65_ALU_ORA: result = acc | data_in;
            `MINI65_ALU_EOR: result = acc ^ data_in;
            // Index register wraps
            `MINI65_ALU_INC: result = x_reg + mini65_pkg::data_t'(1);
            `MINI65_ALU_DEC: result = x_reg - mini65_pkg::data_t'(1);
            `MINI65_ALU_XFER: result = acc;
            `MINI65_ALU_CLC: carry_out = 1'b0;
            `MINI65_ALU_SEC: carry_out = 1'b1;
            default: result = data_in;
        endcase
    end

endmodule

// ==== hw/register_file.sv ====
`timescale 1ns/100ps

module register_file (
    input  logic              fclk,
    input  logic              rst_n,
    input  logic              rdy,
    input  mini65_pkg::data_t result,
    input  logic              carry_out,
    input  logic              a_we,
    input  logic              x_we,
    input  logic              c_we,
    input  logic              store_x,
    output mini65_pkg::data_t acc,
    output mini65_pkg::data_t x_reg,
    output mini65_pkg::data_t data_out,
    output logic              carry
);

    ////////////////////////////////////////////////////////////
    // A, X and carry
    ////////////////////////////////////////////////////////////
    always_ff @(posedge fclk) begin
        if (!rst_n) begin
            acc   <= '0;
            x_reg <= '0;
            carry <= 1'b0;
        end else if (rdy) begin
            // Write-back on the final bus cycle
            if (a_we) begin
                acc <= result;
            end
            if (x_we) begin
                x_reg <= result;
            end
            if (c_we) begin
                carry <= carry_out;
            end
        end
    end

    // Store data, X for STX and A otherwise
    assign data_out = store_x ? x_reg : acc;

endmodule

// ==== hw/address_unit.sv ====
`timescale 1ns/100ps
`include "mini65_defs.svh"

module address_unit (
    input  logic                  fclk,
    input  logic                  rst_n,
    input  logic                  rdy,
    input  mini65_pkg::data_t     data_in,
    input  logic                  pc_inc,
    input  logic                  pc_jump,
    input  logic                  lo_we,
    input  logic                  hi_we,
    input  mini65_pkg::addr_sel_t addr_sel,
    output mini65_pkg::addr_t     addr
);

    mini65_pkg::addr_t pc;
    mini65_pkg::data_t opnd_lo;
    mini65_pkg::data_t opnd_hi;

    ////////////////////////////////////////////////////////////
    // Program counter
    ////////////////////////////////////////////////////////////
    always_ff @(posedge fclk) begin
        if (!rst_n) begin
            pc <= `MINI65_RESET_PC;
        end else if (rdy) begin
            // High byte of JMP target comes straight off the bus
            if (pc_jump) begin
                pc <= {data_in, opnd_lo};
            end else if (pc_inc) begin
                pc <= pc + mini65_pkg::addr_t'(1);
            end
        end
    end

    // Operand address bytes
    always_ff @(posedge fclk) begin
        if (rdy) begin
            if (lo_we) begin
                opnd_lo <= data_in;
            end
            if (hi_we) begin
                opnd_hi <= data_in;
            end
        end
    end

    // Latch only drives the bus in the data cycle
    assign addr = (addr_sel == `MINI65_ADDR_SEL_OPND) ? {opnd_hi, opnd_lo} : pc;

endmodule

// ==== hw/mini65_core.sv ====
`timescale 1ns/100ps

module mini65_core (
    input  logic                fclk,
    input  logic                rst_n,
    input  logic                rdy,
    output mini65_pkg::addr_t   addr,
    input  mini65_pkg::data_t   data_in,
    output mini65_pkg::data_t   data_out,
    output logic                rwb,
    output logic                sync
);

    // Decoder strobes
    mini65_pkg::alu_op_t   alu_op;
    logic                  a_we;
    logic                  x_we;
    logic                  c_we;
    logic                  store_x;
    logic                  pc_inc;
    logic                  pc_jump;
    logic                  lo_we;
    logic                  hi_we;
    mini65_pkg::addr_sel_t addr_sel;

    // Register and execute paths
    mini65_pkg::data_t     acc;
    mini65_pkg::data_t     x_reg;
    logic                  carry;
    mini65_pkg::data_t     result;
    logic                  carry_out;

    ////////////////////////////////////////////////////////////
    // Decode stage
    ////////////////////////////////////////////////////////////
    instruction_decoder i_instruction_decoder (
        .fclk     (fclk),
        .rst_n    (rst_n),
        .rdy      (rdy),
        .data_in  (data_in),
        .alu_op   (alu_op),
        .a_we     (a_we),
        .x_we     (x_we),
        .c_we     (c_we),
        .store_x  (store_x),
        .pc_inc   (pc_inc),
        .pc_jump  (pc_jump),
        .lo_we    (lo_we),
        .hi_we    (hi_we),
        .addr_sel (addr_sel),
        .rwb      (rwb),
        .sync     (sync)
    );

    // Address generation
    address_unit i_address_unit (
        .fclk     (fclk),
        .rst_n    (rst_n),
        .rdy      (rdy),
        .data_in  (data_in),
        .pc_inc   (pc_inc),
        .pc_jump  (pc_jump),
        .lo_we    (lo_we),
        .hi_we    (hi_we),
        .addr_sel (addr_sel),
        .addr     (addr)
    );

    ////////////////////////////////////////////////////////////
    // Execute and result stages
    ////////////////////////////////////////////////////////////
    alu i_alu (
        .alu_op    (alu_op),
        .acc       (acc),
        .x_reg     (x_reg),
        .data_in   (data_in),
        .carry     (carry),
        .result    (result),
        .carry_out (carry_out)
    );

    register_file i_register_file (
        .fclk      (fclk),
        .rst_n     (rst_n),
        .rdy       (rdy),
        .result    (result),
        .carry_out (carry_out),
        .a_we      (a_we),
        .x_we      (x_we),
        .c_we      (c_we),
        .store_x   (store_x),
        .acc       (acc),
        .x_reg     (x_reg),
        .data_out  (data_out),
        .carry     (carry)
    );

endmodule

// ==== testbench/mini65_assertions.sv ====
`timescale 1ns/100ps

module mini65_assertions (
    input logic              fclk,
    input logic              rst_n,
    input logic              rdy,
    input mini65_pkg::addr_t addr,
    input mini65_pkg::data_t data_out,
    input logic              rwb,
    input logic              sync
);

    ////////////////////////////////////////////////////////////
    // Bus protocol
    ////////////////////////////////////////////////////////////

    // Stalled cycle keeps the whole bus frozen
    stall_hold: assert property (@(posedge fclk) disable iff (!rst_n)
        !rdy |=> ($stable(addr) && $stable(rwb) && $stable(data_out)))
        else $error("bus outputs moved while rdy was low");

    // Opcode fetch is always a read
    fetch_is_read: assert property (@(posedge fclk) disable iff (!rst_n)
        sync |-> rwb)
        else $error("write seen during an opcode fetch cycle");

    // First cycle out of reset
    reset_read: assert property (@(posedge fclk)
        $rose(rst_n) |-> rwb)
        else $error("rwb low in the first cycle after reset");

endmodule

bind mini65_core mini65_assertions i_mini65_assertions (
    .fclk     (fclk),
    .rst_n    (rst_n),
    .rdy      (rdy),
    .addr     (addr),
    .data_out (data_out),
    .rwb      (rwb),
    .sync     (sync)
);

// ==== testbench/mini65_tb.sv ====
`timescale 1ns/100ps
`include "mini65_defs.svh"

module mini65_tb;

    localparam int CLK_PERIOD   = 40;
    localparam int DRIVE_DLY    = 2;
    localparam int N_INSTR      = 48;
    localparam int JMP_AT       = 20;
    localparam int STALL_MARGIN = 4;
    // Worst case 4 cycles per instruction, plus reset and tail
    localparam int WATCHDOG_NS  = (N_INSTR + 8) * 4 * STALL_MARGIN * CLK_PERIOD;

    logic              fclk = 1'b0;
    logic              rst_n;
    logic              rdy;
    mini65_pkg::addr_t addr;
    mini65_pkg::data_t data_in;
    mini65_pkg::data_t data_out;
    logic              rwb;
    logic              sync;

    // Bus memory and the reference copy
    mini65_pkg::data_t mem     [0:65535];
    mini65_pkg::data_t ref_mem [0:65535];
    mini65_pkg::addr_t prog_ptr;

    // Expected writes in program order
    mini65_pkg::addr_t exp_addr [$];
    mini65_pkg::data_t exp_data [$];
    int                wr_idx    = 0;
    int                err_count = 0;
    logic [31:0]       rng       = 32'd46859;

    mini65_core i_mini65_core (
        .fclk     (fclk),
        .rst_n    (rst_n),
        .rdy      (rdy),
        .addr     (addr),
        .data_in  (data_in),
        .data_out (data_out),
        .rwb      (rwb),
        .sync     (sync)
    );

    always #(CLK_PERIOD / 2) fclk = ~fclk;

    //////////////////////////////////////////////////////////////
    // Helpers
    //////////////////////////////////////////////////////////////

    // 32-bit xorshift
    function logic [31:0] next_random();
        rng = rng ^ (rng << 13);
        rng = rng ^ (rng >> 17);
        rng = rng ^ (rng << 5);
        return rng;
    endfunction

    task compare_value(input logic [31:0] actual, input logic [31:0] expected,
                       input string what);
        if (actual !== expected) begin
            err_count++;
            $display("Fail %0t: %s is %h, expected %h", $time, what, actual, expected);
        end
    endtask

    function void put_byte(input mini65_pkg::data_t b);
        mem[prog_ptr] = b;
        prog_ptr = prog_ptr + 16'd1;
    endfunction

    // Random opcode pool, last four are unsupported
    function automatic mini65_pkg::data_t opcode_at(input int idx);
        case (idx)
            0:  return `MINI65_OP_LDA_IMM;
            1:  return `MINI65_OP_LDX_IMM;
            2:  return `MINI65_OP_LDA_ABS;
            3:  return `MINI65_OP_STA_ABS;
            4:  return `MINI65_OP_STX_ABS;
            5:  return `MINI65_OP_ADC_IMM;
            6:  return `MINI65_OP_AND_IMM;
            7:  return `MINI65_OP_ORA_IMM;
            8:  return `MINI65_OP_EOR_IMM;
            9:  return `MINI65_OP_INX;
            10: return `MINI65_OP_DEX;
            11: return `MINI65_OP_TAX;
            12: return `MINI65_OP_CLC;
            13: return `MINI65_OP_SEC;
            14: return `MINI65_OP_NOP;
            15: return 8'h00;
            16: return 8'hFF;
            default: return 8'h5A;
        endcase
    endfunction

    //////////////////////////////////////////////////////////////
    // Program image
    //////////////////////////////////////////////////////////////
    task build_program();
        mini65_pkg::addr_t target;
        mini65_pkg::addr_t here;
        mini65_pkg::addr_t a_i;
        mini65_pkg::data_t op;
        logic [31:0]       rnd;
        int                fill_len;
        // Background pattern over the full address
        for (int i = 0; i < 65536; i++) begin
            a_i = i;
            mem[i] = a_i[15:8] ^ a_i[7:0] ^ 8'h3C;
        end
        // Data window for absolute operands
        for (int i = 0; i < 256; i++) begin
            rnd = next_random();
            mem[16'h0300 + i] = rnd[7:0];
        end
        prog_ptr = `MINI65_RESET_PC;
        for (int n = 0; n < N_INSTR; n++) begin
            if (n == JMP_AT) begin
                // Forward jump over stores that must never run
                rnd = next_random();
                fill_len = 1 + rnd % 4;
                target = prog_ptr + 16'd3 + 16'(3 * fill_len);
                put_byte(`MINI65_OP_JMP_ABS);
                put_byte(target[7:0]);
                put_byte(target[15:8]);
                repeat (fill_len) begin
                    put_byte(`MINI65_OP_STA_ABS);
                    put_byte(8'h02);
                    put_byte(8'h04);
                end
            end
            rnd = next_random();
            op = opcode_at(rnd % 18);
            put_byte(op);
            rnd = next_random();
            case (op)
                `MINI65_OP_LDA_IMM, `MINI65_OP_LDX_IMM, `MINI65_OP_ADC_IMM,
                `MINI65_OP_AND_IMM, `MINI65_OP_ORA_IMM, `MINI65_OP_EOR_IMM:
                    put_byte(rnd[7:0]);
                `MINI65_OP_LDA_ABS, `MINI65_OP_STA_ABS, `MINI65_OP_STX_ABS: begin
                    // Sixteen bytes only, so loads often hit earlier stores
                    put_byte({4'h0, rnd[3:0]});
                    put_byte(8'h03);
                end
                default: ;
            endcase
        end
        // Result dump, then park on a self jump
        put_byte(`MINI65_OP_STA_ABS);
        put_byte(8'h00);
        put_byte(8'h04);
        put_byte(`MINI65_OP_STX_ABS);
        put_byte(8'h01);
        put_byte(8'h04);
        here = prog_ptr;
        put_byte(`MINI65_OP_JMP_ABS);
        put_byte(here[7:0]);
        put_byte(here[15:8]);
    endtask

    //////////////////////////////////////////////////////////////
    // Instruction level reference
    //////////////////////////////////////////////////////////////
    function void run_reference();
        mini65_pkg::addr_t pc;
        mini65_pkg::addr_t op_pc;
        mini65_pkg::addr_t opnd;
        mini65_pkg::data_t op;
        mini65_pkg::data_t imm;
        mini65_pkg::data_t a;
        mini65_pkg::data_t x;
        logic              c;
        logic [8:0]        sum;
        logic              parked;
        int                steps;
        for (int i = 0; i < 65536; i++) begin
            ref_mem[i] = mem[i];
        end
        pc = `MINI65_RESET_PC;
        a = 8'h00;
        x = 8'h00;
        c = 1'b0;
        parked = 1'b0;
        steps = 0;
        while (!parked && steps < 4 * N_INSTR) begin
            op_pc = pc;
            op = ref_mem[pc];
            imm = ref_mem[pc + 16'd1];
            opnd = {ref_mem[pc + 16'd2], ref_mem[pc + 16'd1]};
            pc = pc + 16'd1;
            case (op)
                `MINI65_OP_LDA_IMM: a = imm;
                `MINI65_OP_LDX_IMM: x = imm;
                `MINI65_OP_LDA_ABS: a = ref_mem[opnd];
                `MINI65_OP_STA_ABS: begin
                    exp_addr.push_back(opnd);
                    exp_data.push_back(a);
                    ref_mem[opnd] = a;
                end
                `MINI65_OP_STX_ABS: begin
                    exp_addr.push_back(opnd);
                    exp_data.push_back(x);
                    ref_mem[opnd] = x;
                end
                `MINI65_OP_ADC_IMM: begin
                    sum = {1'b0, a} + {1'b0, imm} + {8'b0, c};
                    a = sum[7:0];
                    c = sum[8];
                end
                `MINI65_OP_AND_IMM: a = a & imm;
                `MINI65_OP_ORA_IMM: a = a | imm;
                `MINI65_OP_EOR_IMM: a = a ^ imm;
                `MINI65_OP_INX: x = x + 8'd1;
                `MINI65_OP_DEX: x = x - 8'd1;
                `MINI65_OP_TAX: x = a;
                `MINI65_OP_CLC: c = 1'b0;
                `MINI65_OP_SEC: c = 1'b1;
                `MINI65_OP_JMP_ABS: parked = (opnd == op_pc);
                default: ;
            endcase
            // Operand bytes past the opcode
            case (op)
                `MINI65_OP_LDA_IMM, `MINI65_OP_LDX_IMM, `MINI65_OP_ADC_IMM,
                `MINI65_OP_AND_IMM, `MINI65_OP_ORA_IMM, `MINI65_OP_EOR_IMM:
                    pc = pc + 16'd1;
                `MINI65_OP_LDA_ABS, `MINI65_OP_STA_ABS, `MINI65_OP_STX_ABS:
                    pc = pc + 16'd2;
                `MINI65_OP_JMP_ABS: pc = opnd;
                default: ;
            endcase
            steps++;
        end
    endfunction

    //////////////////////////////////////////////////////////////
    // Bus side processes
    //////////////////////////////////////////////////////////////

    // Inputs change shortly after the edge
    always @(posedge fclk) begin
        #DRIVE_DLY;
        rdy = (next_random() % 4) != 0;
        data_in = mem[addr];
    end

    // Memory write port
    always @(posedge fclk) begin
        if (rst_n && rdy && rwb === 1'b0) begin
            mem[addr] <= data_out;
        end
    end

    // Observed writes against the reference order
    always @(posedge fclk) begin
        if (rst_n && rdy && rwb === 1'b0) begin
            if (wr_idx < exp_addr.size()) begin
                compare_value(addr, exp_addr[wr_idx], $sformatf("write %0d address", wr_idx));
                compare_value(data_out, exp_data[wr_idx], $sformatf("write %0d data", wr_idx));
            end else begin
                err_count++;
                $display("Unexpected write of %h to address %h at %0t %s",
                         data_out, addr, $time, "after the last expected write");
            end
            wr_idx++;
        end
    end

    // Watchdog
    initial begin
        #(WATCHDOG_NS);
        $display("Timeout: only %0d of %0d expected writes seen, errors: %0d",
                 wr_idx, exp_addr.size(), err_count);
        $display("Checks failed");
        $finish;
    end

    //////////////////////////////////////////////////////////////
    // Main sequence
    //////////////////////////////////////////////////////////////
    initial begin
        rst_n   = 1'b0;
        rdy     = 1'b1;
        data_in = '0;
        build_program();
        run_reference();
        $display("Program of %0d instructions, %0d expected writes", N_INSTR, exp_addr.size());
        repeat (4) @(posedge fclk);
        #DRIVE_DLY;
        rst_n = 1'b1;
        #1;
        // First bus cycle out of reset
        compare_value(addr, `MINI65_RESET_PC, "first fetch address");
        compare_value(sync, 1'b1, "first fetch sync");
        compare_value(rwb, 1'b1, "first fetch rwb");
        wait (wr_idx >= exp_addr.size());
        // Self jump must stay silent
        repeat (8) @(posedge fclk);
        $display("Writes seen: %0d, expected: %0d, errors: %0d",
                 wr_idx, exp_addr.size(), err_count);
        if (err_count == 0) begin
            $display("All checks passed");
        end else begin
            $display("Checks failed");
        end
        $finish;
    end

endmodule

// ==== sim.f ====
+incdir+hw
hw/mini65_pkg.sv
hw/instruction_decoder.sv
hw/alu.sv
hw/register_file.sv
hw/address_unit.sv
hw/mini65_core.sv
testbench/mini65_assertions.sv
testbench/mini65_tb.sv
